//--- flist.f
logic/ks_out_pkg.sv
logic/ks_sync_fifo.sv
logic/ks_col_proc.sv
logic/ks_lwe_order.sv
logic/ks_out_process.sv
verification/ks_clk_gen.sv
verification/ks_out_tb.sv

//--- verification/ks_out_tb.sv
/* Feeds whole key-switch loops one lane group at a time, with random LWE
   back-pressure. The next loop starts only once the previous one has drained */
`timescale 1ns/1ps
module ks_out_tb;
  import ks_out_pkg::*;

  localparam logic [31:0] SEED        = 32'h9859_b9ce;
  localparam int          LOOP_NB     = 6;
  localparam int          COL_NB      = LBX * BLOCK_COL_NB;
  localparam int          RST_LIMIT   = 50;
  localparam int          DRAIN_LIMIT = 500;

  logic                  clk;
  logic                  s_rst_n;
  lane_in_t [LBX-1:0]    prod_i;
  logic [LBX-1:0]        prod_avail_i;
  logic [OP_W-1:0]       body_i;
  logic                  body_vld_i;
  logic                  body_rdy_o;
  logic                  body_wr_en_o;
  logic [OP_W-1:0]       body_wr_data_o;
  logic [LWE_COEF_W-1:0] lwe_o;
  logic                  lwe_vld_o;
  logic                  lwe_rdy_i;
  logic                  loop_done_o;
  logic                  lane_done_o;

  // Reference model state
  logic [OP_W-1:0]       body_q[$];
  logic [OP_W-1:0]       bw_q[$];
  logic [LWE_COEF_W:0]   lwe_q[$];
  logic [OP_W-1:0]       exp_bw;
  logic                  exp_bw_vld;
  logic [LWE_COEF_W-1:0] exp_coef;
  logic                  exp_done;
  logic                  exp_lwe_vld;
  logic [LWE_COEF_W-1:0] held_lwe;
  logic                  was_stalled;
  logic                  lwe_hs;
  logic                  bw_pend;
  logic                  body_hs;
  logic [31:0]           data_state;
  logic [31:0]           rdy_state;
  int                    err_value;
  int                    err_other;
  int                    coef_cnt;
  int                    bw_cnt;
  int                    loop_idx;
  bit                    run_ok;
  logic                  lwe_fire;
  logic                  last_lane_end;

  ks_clk_gen u_clk_gen (
    .clk_o     (clk),
    .s_rst_n_o (s_rst_n)
  );

  ks_out_process dut (
    .clk            (clk),
    .s_rst_n        (s_rst_n),
    .prod_i         (prod_i),
    .prod_avail_i   (prod_avail_i),
    .body_i         (body_i),
    .body_vld_i     (body_vld_i),
    .body_rdy_o     (body_rdy_o),
    .body_wr_en_o   (body_wr_en_o),
    .body_wr_data_o (body_wr_data_o),
    .lwe_o          (lwe_o),
    .lwe_vld_o      (lwe_vld_o),
    .lwe_rdy_i      (lwe_rdy_i),
    .loop_done_o    (loop_done_o),
    .lane_done_o    (lane_done_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Round to nearest on the kept top bits, wrapping past the top
  function automatic logic [LWE_COEF_W-1:0] round_coef(input logic [OP_W-1:0] val);
    int unsigned scaled;
    scaled = (int'(val) + (1 << (OP_W - LWE_COEF_W - 1))) >> (OP_W - LWE_COEF_W);
    return scaled[LWE_COEF_W-1:0];
  endfunction

  // ------------------------------------------------------------------------
  // Body offer, LWE ready and expected heads, all on the falling edge
  // ------------------------------------------------------------------------
  always @(negedge clk) begin
    if (body_hs && body_q.size() > 0) begin
      void'(body_q.pop_front());
    end
    body_vld_i = (body_q.size() > 0);
    body_i     = body_vld_i ? body_q[0] : '0;
    body_hs    = body_vld_i & body_rdy_o;
  end

  always @(negedge clk) begin
    if (lwe_hs && lwe_q.size() > 0) begin
      void'(lwe_q.pop_front());
      coef_cnt++;
    end
    if (bw_pend && bw_q.size() > 0) begin
      void'(bw_q.pop_front());
      bw_cnt++;
    end
    exp_lwe_vld           = (lwe_q.size() > 0);
    {exp_done, exp_coef}  = exp_lwe_vld ? lwe_q[0] : '0;
    exp_bw_vld            = (bw_q.size() > 0);
    exp_bw                = exp_bw_vld ? bw_q[0] : '0;
    rdy_state             = xorshift32(rdy_state);
    lwe_rdy_i             = (rdy_state[1:0] != 2'b00);
    // Keep the value seen when a stall begins
    if (!was_stalled) begin
      held_lwe = lwe_o;
    end
    was_stalled = lwe_vld_o & ~lwe_rdy_i;
    lwe_hs      = lwe_vld_o & lwe_rdy_i & s_rst_n;
    bw_pend     = body_wr_en_o & s_rst_n;
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  assign lwe_fire      = lwe_vld_o & lwe_rdy_i;
  assign last_lane_end = prod_avail_i[LBX-1] & prod_i[LBX-1].last_pbs;

  a_lwe_expected: assert property (@(posedge clk) disable iff (!s_rst_n)
    lwe_fire |-> exp_lwe_vld)
    else begin
      err_other++;
      $display("%0t: LWE coefficient handed out with none expected", $time);
    end
  a_lwe_value: assert property (@(posedge clk) disable iff (!s_rst_n)
    (lwe_fire && exp_lwe_vld) |-> (lwe_o == exp_coef))
    else begin
      err_value++;
      $display("[ERROR] %0t lwe_o got %h expected %h", $time, $sampled(lwe_o), exp_coef);
    end
  a_loop_done: assert property (@(posedge clk) disable iff (!s_rst_n)
    (lwe_fire && exp_lwe_vld) |-> (loop_done_o == exp_done))
    else begin
      err_value++;
      $display("[ERROR] %0t loop_done_o got %b expected %b", $time,
               $sampled(loop_done_o), exp_done);
    end
  a_loop_done_hs: assert property (@(posedge clk) disable iff (!s_rst_n)
    loop_done_o |-> lwe_fire)
    else begin
      err_other++;
      $display("%0t: loop_done_o pulsed outside an output handshake", $time);
    end
  a_lwe_hold: assert property (@(posedge clk) disable iff (!s_rst_n)
    (lwe_vld_o && !lwe_rdy_i) |=> (lwe_vld_o && lwe_o == held_lwe))
    else begin
      err_value++;
      $display("[ERROR] %0t lwe_o got %h expected %h", $time, $sampled(lwe_o), held_lwe);
    end
  a_body_expected: assert property (@(posedge clk) disable iff (!s_rst_n)
    body_wr_en_o |-> exp_bw_vld)
    else begin
      err_other++;
      $display("%0t: body write with no body expected", $time);
    end
  a_body_value: assert property (@(posedge clk) disable iff (!s_rst_n)
    (body_wr_en_o && exp_bw_vld) |-> (body_wr_data_o == exp_bw))
    else begin
      err_value++;
      $display("[ERROR] %0t body_wr_data_o got %h expected %h", $time,
               $sampled(body_wr_data_o), exp_bw);
    end
  a_lane_done_set: assert property (@(posedge clk) disable iff (!s_rst_n)
    last_lane_end |-> ##2 lane_done_o)
    else begin
      err_value++;
      $display("[ERROR] %0t lane_done_o got 0 expected 1", $time);
    end
  a_lane_done_clr: assert property (@(posedge clk) disable iff (!s_rst_n)
    lane_done_o |-> $past(last_lane_end, 2))
    else begin
      err_value++;
      $display("[ERROR] %0t lane_done_o got 1 expected 0", $time);
    end

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  task automatic wait_reset(output bit ok);
    int cyc;
    ok = 1'b0;
    for (cyc = 0; cyc < RST_LIMIT && !ok; cyc++) begin
      @(negedge clk);
      ok = (s_rst_n === 1'b1);
    end
    if (!ok) begin
      err_other++;
      $display("Reset was never released within %0d cycles", RST_LIMIT);
    end
  endtask

  task automatic run_loop();
    logic [OP_W-1:0] prod_mem [COL_NB][BATCH_PBS_NB];
    logic [OP_W-1:0] body;
    logic [OP_W-1:0] neg;
    logic            tag;
    int              col;
    int              pbs;
    int              pass;
    int              lane;
    int              gap;

    // Whole loop is drawn first, expected order comes from column order
    for (col = 0; col < COL_NB; col++) begin
      for (pbs = 0; pbs < BATCH_PBS_NB; pbs++) begin
        data_state         = xorshift32(data_state);
        prod_mem[col][pbs] = data_state[OP_W-1:0];
      end
    end
    for (pbs = 0; pbs < BATCH_PBS_NB; pbs++) begin
      data_state = xorshift32(data_state);
      body       = data_state[OP_W+7:8];
      body_q.push_back(body);
      bw_q.push_back(body - prod_mem[LWE_K][pbs]);
    end
    // Tag closes each lane round and the last mask column
    for (col = 0; col < LWE_K; col++) begin
      for (pbs = 0; pbs < BATCH_PBS_NB; pbs++) begin
        neg = '0 - prod_mem[col][pbs];
        tag = (pbs == BATCH_PBS_NB - 1) && ((col % LBX == LBX - 1) || (col == LWE_K - 1));
        lwe_q.push_back({tag, round_coef(neg)});
      end
    end

    for (pass = 0; pass < BLOCK_COL_NB; pass++) begin
      for (lane = 0; lane < LBX; lane++) begin
        col = pass * LBX + lane;
        for (pbs = 0; pbs < BATCH_PBS_NB; pbs++) begin
          prod_avail_i          = '0;
          prod_avail_i[lane]    = 1'b1;
          prod_i[lane].data     = prod_mem[col][pbs];
          prod_i[lane].last_pbs = (pbs == BATCH_PBS_NB - 1);
          @(negedge clk);
        end
        prod_avail_i = '0;
        prod_i       = '0;
        data_state   = xorshift32(data_state);
        gap          = data_state % 3;
        repeat (gap) @(negedge clk);
      end
    end
  endtask

  task automatic wait_drain(input int idx, output bit ok);
    int cyc;
    ok = 1'b0;
    for (cyc = 0; cyc < DRAIN_LIMIT && !ok; cyc++) begin
      @(negedge clk);
      ok = (lwe_q.size() == 0) && (bw_q.size() == 0) && (body_q.size() == 0);
    end
    if (!ok) begin
      err_other++;
      $display("Loop %0d did not drain in %0d cycles, %0d coefficients and %0d body writes missing",
               idx, DRAIN_LIMIT, lwe_q.size(), bw_q.size());
    end
  endtask

  initial begin
    prod_i       = '0;
    prod_avail_i = '0;
    body_i       = '0;
    body_vld_i   = 1'b0;
    lwe_rdy_i    = 1'b0;
    body_hs      = 1'b0;
    lwe_hs       = 1'b0;
    bw_pend      = 1'b0;
    was_stalled  = 1'b0;
    err_value    = 0;
    err_other    = 0;
    coef_cnt     = 0;
    bw_cnt       = 0;
    data_state   = SEED;
    // Separate stream for back-pressure
    rdy_state    = ~SEED;

    wait_reset(run_ok);
    repeat (2) @(negedge clk);
    for (loop_idx = 0; loop_idx < LOOP_NB && run_ok; loop_idx++) begin
      run_loop();
      wait_drain(loop_idx, run_ok);
    end
    // Stray outputs after the last loop still meet the checks
    repeat (10) @(negedge clk);

    $display("Summary: %0d coefficients, %0d body writes, %0d value errors, %0d other errors",
             coef_cnt, bw_cnt, err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verification/ks_clk_gen.sv
/* Free-running 20 ns clock. Reset is held low over the first RST_CYCLES
   rising edges and released on a falling edge */
`timescale 1ns/1ps
module ks_clk_gen #(
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic s_rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    s_rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    s_rst_n_o = 1'b1;
  end

endmodule

//--- logic/ks_out_process.sv
/* Key-switch output stage. Products are strobes with no back-pressure, so
   lwe_rdy_i must not stay low long enough to fill a lane FIFO */
`timescale 1ns/1ps
module ks_out_process (
  input  logic                                       clk,
  input  logic                                       s_rst_n,
  input  ks_out_pkg::lane_in_t [ks_out_pkg::LBX-1:0] prod_i,
  input  logic [ks_out_pkg::LBX-1:0]                 prod_avail_i,
  input  logic [ks_out_pkg::OP_W-1:0]                body_i,
  input  logic                                       body_vld_i,
  output logic                                       body_rdy_o,
  output logic                                       body_wr_en_o,
  output logic [ks_out_pkg::OP_W-1:0]                body_wr_data_o,
  output logic [ks_out_pkg::LWE_COEF_W-1:0]          lwe_o,
  output logic                                       lwe_vld_o,
  input  logic                                       lwe_rdy_i,
  output logic                                       loop_done_o,
  output logic                                       lane_done_o
);
  import ks_out_pkg::*;

  // Input register
  lane_in_t [LBX-1:0] s0_prod;
  logic [LBX-1:0]     s0_avail;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s0_avail <= '0;
    end else begin
      s0_avail <= prod_avail_i;
    end
  end

  always_ff @(posedge clk) begin
    s0_prod <= prod_i;
  end

  // Body skid FIFO
  logic [OP_W-1:0] s0_body;
  logic            s0_body_vld;
  logic            s0_body_rdy;

  ks_sync_fifo #(
    .data_t (logic [OP_W-1:0]),
    .DEPTH  (2)
  ) u_body_fifo (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .in_data_i  (body_i),
    .in_vld_i   (body_vld_i),
    .in_rdy_o   (body_rdy_o),
    .out_data_o (s0_body),
    .out_vld_o  (s0_body_vld),
    .out_rdy_i  (s0_body_rdy)
  );

  // ------------------------------------------------------------------------
  // Lanes
  // ------------------------------------------------------------------------
  logic [LBX-1:0]           x_body_take;
  logic [LBX-1:0]           x_body_wr_en;
  logic [LBX-1:0][OP_W-1:0] x_body_wr_data;
  xdata_t [LBX-1:0]         x_data;
  logic [LBX-1:0]           x_vld;
  logic [LBX-1:0]           x_rdy;

  for (genvar gi = 0; gi < LBX; gi++) begin : g_lane
    ks_col_proc #(
      .LANE_ID (gi)
    ) u_col_proc (
      .clk            (clk),
      .s_rst_n        (s_rst_n),
      .prod_i         (s0_prod[gi]),
      .prod_avail_i   (s0_avail[gi]),
      .body_i         (s0_body),
      .body_vld_i     (s0_body_vld),
      .body_take_o    (x_body_take[gi]),
      .body_wr_en_o   (x_body_wr_en[gi]),
      .body_wr_data_o (x_body_wr_data[gi]),
      .x_data_o       (x_data[gi]),
      .x_vld_o        (x_vld[gi]),
      .x_rdy_i        (x_rdy[gi])
    );
  end

  assign s0_body_rdy = |x_body_take;

  // Only one lane owns the body column
  logic [OP_W-1:0] body_wr_data_d;

  always_comb begin
    body_wr_data_d = '0;
    for (int i = 0; i < LBX; i++) begin
      body_wr_data_d = body_wr_data_d | (x_body_wr_data[i] & {OP_W{x_body_wr_en[i]}});
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      body_wr_en_o <= 1'b0;
      lane_done_o  <= 1'b0;
    end else begin
      body_wr_en_o <= |x_body_wr_en;
      lane_done_o  <= s0_avail[LBX-1] & s0_prod[LBX-1].last_pbs;
    end
  end

  always_ff @(posedge clk) begin
    body_wr_data_o <= body_wr_data_d;
  end

  ks_lwe_order u_lwe_order (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .x_data_i    (x_data),
    .x_vld_i     (x_vld),
    .x_rdy_o     (x_rdy),
    .lwe_o       (lwe_o),
    .lwe_vld_o   (lwe_vld_o),
    .lwe_rdy_i   (lwe_rdy_i),
    .loop_done_o (loop_done_o)
  );

endmodule

//--- logic/ks_lwe_order.sv
/* Drains the lane FIFOs in LWE order, one lane at a time. A lane hands over
   all PBS of its column before the pointer moves to the next lane */
`timescale 1ns/1ps
module ks_lwe_order (
  input  logic                                     clk,
  input  logic                                     s_rst_n,
  input  ks_out_pkg::xdata_t [ks_out_pkg::LBX-1:0] x_data_i,
  input  logic [ks_out_pkg::LBX-1:0]               x_vld_i,
  output logic [ks_out_pkg::LBX-1:0]               x_rdy_o,
  output logic [ks_out_pkg::LWE_COEF_W-1:0]        lwe_o,
  output logic                                     lwe_vld_o,
  input  logic                                     lwe_rdy_i,
  output logic                                     loop_done_o
);
  import ks_out_pkg::*;

  // ------------------------------------------------------------------------
  // Lane selection
  // ------------------------------------------------------------------------
  logic [LBX_W-1:0] l_id;
  logic             l_last_id;
  xdata_t           l_data;
  logic             l_vld;
  logic             l_wrap;
  logic             l_push;

  lwe_out_t         lf_in_data;
  logic             lf_in_rdy;
  lwe_out_t         lf_out_data;
  logic             lf_out_vld;

  assign l_data    = x_data_i[l_id];
  assign l_vld     = x_vld_i[l_id];
  assign l_last_id = (l_id == LBX_W'(LBX - 1));
  // Early wrap after the last mask column
  assign l_wrap    = l_data.last_pbs & (l_last_id | l_data.last_mask);
  assign l_push    = l_vld & lf_in_rdy;

  always_comb begin
    for (int i = 0; i < LBX; i++) begin
      x_rdy_o[i] = (l_id == LBX_W'(i)) & lf_in_rdy;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      l_id <= '0;
    end else if (l_push && l_data.last_pbs) begin
      l_id <= l_wrap ? '0 : l_id + 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // Output FIFO
  // ------------------------------------------------------------------------
  assign lf_in_data.coef      = l_data.coef;
  assign lf_in_data.loop_done = l_wrap;

  ks_sync_fifo #(
    .data_t (lwe_out_t),
    .DEPTH  (LFIFO_DEPTH)
  ) u_lfifo (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .in_data_i  (lf_in_data),
    .in_vld_i   (l_vld),
    .in_rdy_o   (lf_in_rdy),
    .out_data_o (lf_out_data),
    .out_vld_o  (lf_out_vld),
    .out_rdy_i  (lwe_rdy_i)
  );

  assign lwe_o       = lf_out_data.coef;
  assign lwe_vld_o   = lf_out_vld;
  // Pulse only on the handshake of the tagged entry
  assign loop_done_o = lf_out_data.loop_done & lf_out_vld & lwe_rdy_i;

endmodule

//--- logic/ks_col_proc.sv
/* One column lane. Products cannot be stalled, so the body must be valid
   when the body column arrives and the lane FIFO must have room */
`timescale 1ns/1ps
module ks_col_proc #(
  parameter int LANE_ID = 0
) (
  input  logic                        clk,
  input  logic                        s_rst_n,
  input  ks_out_pkg::lane_in_t        prod_i,
  input  logic                        prod_avail_i,
  input  logic [ks_out_pkg::OP_W-1:0] body_i,
  input  logic                        body_vld_i,
  output logic                        body_take_o,
  output logic                        body_wr_en_o,
  output logic [ks_out_pkg::OP_W-1:0] body_wr_data_o,
  output ks_out_pkg::xdata_t          x_data_o,
  output logic                        x_vld_o,
  input  logic                        x_rdy_i
);
  import ks_out_pkg::*;

  // ------------------------------------------------------------------------
  // Column counter
  // ------------------------------------------------------------------------
  logic [COL_W-1:0]       s0_col;
  logic [BLOCK_COL_W-1:0] s0_pass;
  logic                   s0_last_pass;
  logic                   s0_next;

  assign s0_next      = prod_avail_i & prod_i.last_pbs;
  assign s0_last_pass = (s0_pass == BLOCK_COL_W'(BLOCK_COL_NB - 1));

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s0_col  <= COL_W'(LANE_ID);
      s0_pass <= '0;
    end else if (s0_next) begin
      if (s0_last_pass) begin
        s0_col  <= COL_W'(LANE_ID);
        s0_pass <= '0;
      end else begin
        s0_col  <= s0_col + COL_W'(LBX);
        s0_pass <= s0_pass + 1'b1;
      end
    end
  end

  // s0: subtraction, wraps mod 2^OP_W
  logic            s0_is_body;
  logic            s0_keep;
  logic            s0_last_mask;
  logic [OP_W-1:0] s0_base;
  logic [OP_W-1:0] s0_coef;

  assign s0_is_body   = (s0_col == COL_W'(LWE_K));
  assign s0_keep      = (s0_col <= COL_W'(LWE_K));
  assign s0_last_mask = (s0_col == COL_W'(LWE_K - 1));
  assign s0_base      = s0_is_body ? body_i : '0;
  assign s0_coef      = s0_base - prod_i.data;
  assign body_take_o  = prod_avail_i & s0_is_body;

  // s1: mod switch
  logic                  s1_mask_avail;
  logic                  s1_body_avail;
  logic [OP_W-1:0]       s1_coef;
  logic                  s1_last_pbs;
  logic                  s1_last_mask;
  logic [LWE_COEF_W-1:0] s1_mdsw;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s1_mask_avail <= 1'b0;
      s1_body_avail <= 1'b0;
    end else begin
      // Columns past the body are dropped here
      s1_mask_avail <= prod_avail_i & s0_keep & ~s0_is_body;
      s1_body_avail <= body_take_o;
    end
  end

  always_ff @(posedge clk) begin
    s1_coef      <= s0_coef;
    s1_last_pbs  <= prod_i.last_pbs;
    s1_last_mask <= s0_last_mask;
  end

  // Top bits, rounded with the first dropped bit
  assign s1_mdsw = s1_coef[OP_W-1 -: LWE_COEF_W]
                 + LWE_COEF_W'(s1_coef[OP_W-1-LWE_COEF_W]);

  assign body_wr_en_o   = s1_body_avail;
  assign body_wr_data_o = s1_coef;

  // s2: lane FIFO push
  logic   s2_vld;
  logic   s2_rdy;
  xdata_t s2_data;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s2_vld <= 1'b0;
    end else begin
      s2_vld <= s1_mask_avail;
    end
  end

  always_ff @(posedge clk) begin
    s2_data.coef      <= s1_mdsw;
    s2_data.last_pbs  <= s1_last_pbs;
    s2_data.last_mask <= s1_last_mask;
  end

  ks_sync_fifo #(
    .data_t (xdata_t),
    .DEPTH  (XFIFO_DEPTH)
  ) u_xfifo (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .in_data_i  (s2_data),
    .in_vld_i   (s2_vld),
    .in_rdy_o   (s2_rdy),
    .out_data_o (x_data_o),
    .out_vld_o  (x_vld_o),
    .out_rdy_i  (x_rdy_i)
  );

  // Body FIFO upstream must already hold the body of this PBS
  a_body_ready: assert property (@(posedge clk) disable iff (!s_rst_n)
    body_take_o |-> body_vld_i);
  a_xfifo_room: assert property (@(posedge clk) disable iff (!s_rst_n)
    s2_vld |-> s2_rdy);

endmodule

//--- logic/ks_sync_fifo.sv
/* Register-array FIFO for any packed payload. DEPTH must be at least 2, and
   in_rdy_o is registered so it stays low until one cycle after reset */
`timescale 1ns/1ps
module ks_sync_fifo #(
  parameter type data_t = logic,
  parameter int  DEPTH  = 2
) (
  input  logic  clk,
  input  logic  s_rst_n,
  input  data_t in_data_i,
  input  logic  in_vld_i,
  output logic  in_rdy_o,
  output data_t out_data_o,
  output logic  out_vld_o,
  input  logic  out_rdy_i
);

  data_t                      mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] cnt;
  logic [$clog2(DEPTH+1)-1:0] cnt_d;
  logic                       rdy_q;
  logic                       full;
  logic                       empty;
  logic                       push;
  logic                       pop;

  assign full       = ~rdy_q;
  assign empty      = (cnt == '0);
  assign push       = in_vld_i & ~full;
  assign pop        = out_vld_o & out_rdy_i;
  assign in_rdy_o   = ~full;
  assign out_vld_o  = ~empty;
  assign out_data_o = mem[rd_ptr];

  always_comb begin
    cnt_d = cnt;
    if (push && !pop) begin
      cnt_d = cnt + 1'b1;
    end else if (pop && !push) begin
      cnt_d = cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
      rdy_q  <= 1'b0;
    end else begin
      cnt   <= cnt_d;
      rdy_q <= (int'(cnt_d) < DEPTH);
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // Registered ready must never let a write through on a full array
  a_no_overflow: assert property (@(posedge clk) disable iff (!s_rst_n)
    push |-> (int'(cnt) < DEPTH));
  // Pointers meet whenever the count says empty
  a_no_underflow: assert property (@(posedge clk) disable iff (!s_rst_n)
    empty |-> (wr_ptr == rd_ptr));

endmodule

//--- logic/ks_out_pkg.sv
/* Sizes and shared types of the key-switch output stage. Column LWE_K holds
   the body, and OP_W must be larger than LWE_COEF_W for the mod switch */
package ks_out_pkg;

  // ------------------------------------------------------------------------
  // Base sizes
  // ------------------------------------------------------------------------
  localparam int LBX          = 2;
  localparam int OP_W         = 16;
  localparam int LWE_COEF_W   = 8;
  localparam int LWE_K        = 5;
  localparam int BATCH_PBS_NB = 3;

  // Derived sizes
  localparam int COL_W        = $clog2(LWE_K + 1 + LBX);
  localparam int BLOCK_COL_NB = (LWE_K + 1 + LBX - 1) / LBX;
  localparam int BLOCK_COL_W  = (BLOCK_COL_NB > 1) ? $clog2(BLOCK_COL_NB) : 1;
  localparam int LBX_W        = (LBX > 1) ? $clog2(LBX) : 1;
  localparam int XFIFO_DEPTH  = (BATCH_PBS_NB < 2) ? 2 : BATCH_PBS_NB;
  localparam int LFIFO_DEPTH  = LBX * BATCH_PBS_NB * 2;

  // ------------------------------------------------------------------------
  // Payloads
  // ------------------------------------------------------------------------
  // One product of a lane, the lane is given by the array index
  typedef struct packed {
    logic            last_pbs;
    logic [OP_W-1:0] data;
  } lane_in_t;

  // Lane FIFO entry
  typedef struct packed {
    logic                  last_pbs;
    logic                  last_mask;
    logic [LWE_COEF_W-1:0] coef;
  } xdata_t;

  // Output FIFO entry
  typedef struct packed {
    logic                  loop_done;
    logic [LWE_COEF_W-1:0] coef;
  } lwe_out_t;

endpackage
